// File: Bender.yml
package:
  name: flow_table

sources:
  - include_dirs:
      - hw
    files:
      - hw/flow_table_pkg.sv
      - hw/subtable_if.sv
      - hw/flow_hash.sv
      - hw/flow_subtables.sv
      - hw/read_timer.sv
      - hw/lookup_fsm.sv
      - hw/placement_fsm.sv
      - hw/flow_table.sv
  - target: test
    include_dirs:
      - hw
    files:
      - sim/clk_gen.sv
      - sim/tb_flow_table.sv

// File: flist.f
+incdir+hw
hw/flow_table_pkg.sv
hw/subtable_if.sv
hw/flow_hash.sv
hw/flow_subtables.sv
hw/read_timer.sv
hw/lookup_fsm.sv
hw/placement_fsm.sv
hw/flow_table.sv
sim/clk_gen.sv
sim/tb_flow_table.sv

// File: hw/flow_hash.sv
`timescale 1ns/1ps
`default_nettype none
`include "flow_table_macros.svh"

module flow_hash #(
    parameter type payload_t = flow_table_pkg::meta_t
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire flow_table_pkg::tuple_t in_tuple,
    input  wire payload_t               in_payload,
    input  wire                         in_valid,
    input  wire                         stall,
    output logic                        in_ready,
    output flow_table_pkg::way_idx_t    hash_idx,
    output payload_t                    hash_payload,
    output logic                        hash_valid
);
    import flow_table_pkg::*;

    logic [`FT_HASH_LAT-1:0] valid_q;
    way_idx_t                idx_q     [`FT_HASH_LAT];
    payload_t                payload_q [`FT_HASH_LAT];
    way_idx_t                idx_d;

    // Rotate left by 7 bits per way, then XOR the index-sized chunks together
    function automatic logic [`FT_AWIDTH-1:0] fold_idx(input tuple_t t, input int way);
        logic [2*`FT_TUPLE_W-1:0] dbl;
        tuple_t                   rot;
        logic [`FT_AWIDTH-1:0]    h;
        dbl = {t, t} << ((7 * way) % `FT_TUPLE_W);
        rot = dbl[2*`FT_TUPLE_W-1 -: `FT_TUPLE_W];
        h   = '0;
        for (int c = 0; c < `FT_TUPLE_W / `FT_AWIDTH; c++) begin
            h ^= rot[c*`FT_AWIDTH +: `FT_AWIDTH];
        end
        return h;
    endfunction

    always_comb begin
        for (int w = 0; w < `FT_WAYS; w++) begin
            idx_d[w] = fold_idx(in_tuple, w);
        end
    end

    assign in_ready = !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (!stall) begin
            valid_q <= {valid_q[`FT_HASH_LAT-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            idx_q[0]     <= idx_d;
            payload_q[0] <= in_payload;
            for (int k = 1; k < `FT_HASH_LAT; k++) begin
                idx_q[k]     <= idx_q[k-1];
                payload_q[k] <= payload_q[k-1];
            end
        end
    end

    assign hash_valid   = valid_q[`FT_HASH_LAT-1];
    assign hash_idx     = idx_q[`FT_HASH_LAT-1];
    assign hash_payload = payload_q[`FT_HASH_LAT-1];

    // A result waiting on a busy FSM must not move
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        stall && hash_valid |=> hash_valid && $stable(hash_payload) && $stable(hash_idx));

endmodule

`default_nettype wire

// File: hw/flow_subtables.sv
`timescale 1ns/1ps
`default_nettype none
`include "flow_table_macros.svh"

module flow_subtables (
    input  wire            clk,
    input  wire            rst,
    subtable_if.memory     port_a,
    subtable_if.memory     port_b,
    output logic           init_done
);
    import flow_table_pkg::*;

    localparam int DEPTH = 1 << `FT_AWIDTH;

    fce_t                  mem  [`FT_WAYS][DEPTH];
    fce_t                  rd_a [`FT_WAYS];
    fce_t                  rd_b [`FT_WAYS];
    logic [`FT_AWIDTH-1:0] sweep_idx;

    // Clear one entry per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_idx <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == '1) begin
                init_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `FT_WAYS; w++) begin
            if (!init_done) begin
                mem[w][sweep_idx] <= '0;
            end else if (port_b.wren[w]) begin
                mem[w][port_b.idx[w]] <= port_b.wdata;
            end
        end
    end

    // Two register stages on each read port
    always_ff @(posedge clk) begin
        for (int w = 0; w < `FT_WAYS; w++) begin
            if (port_a.rden[w]) begin
                rd_a[w] <= mem[w][port_a.idx[w]];
            end
            if (port_b.rden[w]) begin
                rd_b[w] <= mem[w][port_b.idx[w]];
            end
            port_a.q[w] <= rd_a[w];
            port_b.q[w] <= rd_b[w];
        end
    end

    a_port_a_read_only: assert property (@(posedge clk) disable iff (rst)
        port_a.wren == '0);

endmodule

`default_nettype wire

// File: hw/flow_table.sv
`timescale 1ns/1ps
`default_nettype none

module flow_table (
    input  wire                        clk,
    input  wire                        rst,
    input  wire flow_table_pkg::meta_t in_meta_data,
    input  wire                        in_meta_valid,
    output logic                       in_meta_ready,
    input  wire flow_table_pkg::ctrl_t in_ctrl_data,
    input  wire                        in_ctrl_valid,
    output logic                       in_ctrl_ready,
    output flow_table_pkg::meta_t      out_meta_data,
    output logic                       out_meta_valid,
    input  wire                        out_meta_ready,
    output logic                       out_ctrl_done
);
    import flow_table_pkg::*;

    way_idx_t meta_idx;
    meta_t    meta_hash;
    logic     meta_hash_valid;
    logic     meta_stall;
    logic     meta_rd_start;
    logic     meta_rd_done;

    way_idx_t ctrl_idx;
    ctrl_t    ctrl_hash;
    logic     ctrl_hash_valid;
    logic     ctrl_stall;
    logic     ctrl_rd_start;
    logic     ctrl_rd_done;

    logic     init_done;

    // Port A serves lookups, port B serves placement
    subtable_if mem_a ();
    subtable_if mem_b ();

    flow_hash #(.payload_t(meta_t)) u_meta_hash (
        .clk          (clk),
        .rst          (rst),
        .in_tuple     (in_meta_data.tuple),
        .in_payload   (in_meta_data),
        .in_valid     (in_meta_valid),
        .stall        (meta_stall),
        .in_ready     (in_meta_ready),
        .hash_idx     (meta_idx),
        .hash_payload (meta_hash),
        .hash_valid   (meta_hash_valid)
    );

    flow_hash #(.payload_t(ctrl_t)) u_ctrl_hash (
        .clk          (clk),
        .rst          (rst),
        .in_tuple     (in_ctrl_data.tuple),
        .in_payload   (in_ctrl_data),
        .in_valid     (in_ctrl_valid),
        .stall        (ctrl_stall),
        .in_ready     (in_ctrl_ready),
        .hash_idx     (ctrl_idx),
        .hash_payload (ctrl_hash),
        .hash_valid   (ctrl_hash_valid)
    );

    flow_subtables u_subtables (
        .clk       (clk),
        .rst       (rst),
        .port_a    (mem_a.memory),
        .port_b    (mem_b.memory),
        .init_done (init_done)
    );

    read_timer u_meta_timer (
        .clk   (clk),
        .rst   (rst),
        .start (meta_rd_start),
        .done  (meta_rd_done)
    );

    read_timer u_ctrl_timer (
        .clk   (clk),
        .rst   (rst),
        .start (ctrl_rd_start),
        .done  (ctrl_rd_done)
    );

    lookup_fsm u_lookup (
        .clk            (clk),
        .rst            (rst),
        .hash_idx       (meta_idx),
        .hash_payload   (meta_hash),
        .hash_valid     (meta_hash_valid),
        .init_done      (init_done),
        .rd_done        (meta_rd_done),
        .rd_start       (meta_rd_start),
        .mem            (mem_a.client),
        .stall          (meta_stall),
        .out_meta_data  (out_meta_data),
        .out_meta_valid (out_meta_valid),
        .out_meta_ready (out_meta_ready)
    );

    placement_fsm u_placement (
        .clk          (clk),
        .rst          (rst),
        .hash_idx     (ctrl_idx),
        .hash_payload (ctrl_hash),
        .hash_valid   (ctrl_hash_valid),
        .init_done    (init_done),
        .rd_done      (ctrl_rd_done),
        .rd_start     (ctrl_rd_start),
        .mem          (mem_b.client),
        .stall        (ctrl_stall),
        .ctrl_done    (out_ctrl_done)
    );

endmodule

`default_nettype wire

// File: hw/flow_table_macros.svh
`ifndef FLOW_TABLE_MACROS_SVH
`define FLOW_TABLE_MACROS_SVH

// Table geometry
`define FT_WAYS     4
`define FT_AWIDTH   4

// Field widths
`define FT_TUPLE_W  32
`define FT_HADDR_W  32
`define FT_LEN_W    16

// Pipeline depths in cycles
`define FT_HASH_LAT 2
`define FT_READ_LAT 2

`endif

// File: hw/flow_table_pkg.sv
`default_nettype none
`include "flow_table_macros.svh"

package flow_table_pkg;

    typedef logic [`FT_TUPLE_W-1:0] tuple_t;
    typedef logic [`FT_HADDR_W-1:0] haddr_t;

    // One entry of a subtable
    typedef struct packed {
        logic   valid;
        tuple_t tuple;
        haddr_t haddr;
    } fce_t;

    typedef struct packed {
        tuple_t                tuple;
        haddr_t                haddr;
        logic [`FT_LEN_W-1:0]  len;
    } meta_t;

    typedef struct packed {
        tuple_t tuple;
        haddr_t haddr;
    } ctrl_t;

    typedef logic [`FT_WAYS-1:0] way_mask_t;

    // Index into each way, way 0 in the low bits
    typedef logic [`FT_WAYS-1:0][`FT_AWIDTH-1:0] way_idx_t;

endpackage

`default_nettype wire

// File: hw/lookup_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "flow_table_macros.svh"

module lookup_fsm (
    input  wire                           clk,
    input  wire                           rst,
    input  wire flow_table_pkg::way_idx_t hash_idx,
    input  wire flow_table_pkg::meta_t    hash_payload,
    input  wire                           hash_valid,
    input  wire                           init_done,
    input  wire                           rd_done,
    output logic                          rd_start,
    subtable_if.client                    mem,
    output logic                          stall,
    output flow_table_pkg::meta_t         out_meta_data,
    output logic                          out_meta_valid,
    input  wire                           out_meta_ready
);
    import flow_table_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        RESPOND
    } state_t;

    state_t    state;
    meta_t     meta_q;
    way_mask_t hit;
    haddr_t    hit_haddr;
    logic      take;

    assign take  = (state == IDLE) && hash_valid && init_done;
    assign stall = (state != IDLE) || !init_done;

    // Lookup side never writes
    assign mem.wren  = '0;
    assign mem.wdata = '0;

    // Lowest matching way wins, zero address on a miss
    always_comb begin
        hit_haddr = '0;
        for (int w = `FT_WAYS - 1; w >= 0; w--) begin
            hit[w] = mem.q[w].valid && (mem.q[w].tuple == meta_q.tuple);
            if (hit[w]) begin
                hit_haddr = mem.q[w].haddr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= IDLE;
            rd_start       <= 1'b0;
            mem.rden       <= '0;
            out_meta_valid <= 1'b0;
        end else begin
            rd_start <= take;
            mem.rden <= take ? '1 : '0;
            case (state)
                IDLE: begin
                    if (take) begin
                        state <= READ;
                    end
                end
                READ: begin
                    if (rd_done) begin
                        out_meta_valid <= 1'b1;
                        state          <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (out_meta_ready) begin
                        out_meta_valid <= 1'b0;
                        state          <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            mem.idx <= hash_idx;
            meta_q  <= hash_payload;
        end
        if (state == READ && rd_done) begin
            out_meta_data <= '{tuple: meta_q.tuple, haddr: hit_haddr, len: meta_q.len};
        end
    end

endmodule

`default_nettype wire

// File: hw/placement_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "flow_table_macros.svh"

module placement_fsm (
    input  wire                           clk,
    input  wire                           rst,
    input  wire flow_table_pkg::way_idx_t hash_idx,
    input  wire flow_table_pkg::ctrl_t    hash_payload,
    input  wire                           hash_valid,
    input  wire                           init_done,
    input  wire                           rd_done,
    output logic                          rd_start,
    subtable_if.client                    mem,
    output logic                          stall,
    output logic                          ctrl_done
);
    import flow_table_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DECIDE,
        WRITE
    } state_t;

    state_t    state;
    ctrl_t     ctrl_q;
    way_mask_t hit;
    way_mask_t empty;
    way_mask_t hit_q;
    way_mask_t empty_q;
    way_mask_t pick;
    logic      take;

    assign take  = (state == IDLE) && hash_valid && init_done;
    assign stall = (state != IDLE) || !init_done;

    always_comb begin
        for (int w = 0; w < `FT_WAYS; w++) begin
            hit[w]   = mem.q[w].valid && (mem.q[w].tuple == ctrl_q.tuple);
            empty[w] = !mem.q[w].valid;
        end
    end

    // Lowest hit first, else lowest empty way; all zero drops the record
    assign pick = (hit_q != '0) ? (hit_q & (~hit_q + 1'b1))
                                : (empty_q & (~empty_q + 1'b1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            rd_start  <= 1'b0;
            mem.rden  <= '0;
            mem.wren  <= '0;
            ctrl_done <= 1'b0;
        end else begin
            rd_start  <= take;
            mem.rden  <= take ? '1 : '0;
            mem.wren  <= '0;
            ctrl_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (take) begin
                        state <= READ;
                    end
                end
                READ: begin
                    if (rd_done) begin
                        state <= DECIDE;
                    end
                end
                DECIDE: begin
                    mem.wren  <= pick;
                    ctrl_done <= 1'b1;
                    state     <= WRITE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            mem.idx <= hash_idx;
            ctrl_q  <= hash_payload;
        end
        if (state == READ && rd_done) begin
            hit_q   <= hit;
            empty_q <= empty;
        end
        if (state == DECIDE) begin
            mem.wdata <= '{valid: 1'b1, tuple: ctrl_q.tuple, haddr: ctrl_q.haddr};
        end
    end

    a_single_write: assert property (@(posedge clk) disable iff (rst)
        $onehot0(mem.wren));

endmodule

`default_nettype wire

// File: hw/read_timer.sv
`timescale 1ns/1ps
`default_nettype none
`include "flow_table_macros.svh"

module read_timer (
    input  wire  clk,
    input  wire  rst,
    input  wire  start,
    output logic done
);
    localparam int CNT_W = $clog2(`FT_READ_LAT + 1);

    logic [CNT_W-1:0] cnt;

    // Counts down to one in the cycle the read data lands
    assign done = (cnt == CNT_W'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= CNT_W'(`FT_READ_LAT);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        start |=> !start [*`FT_READ_LAT]);

endmodule

`default_nettype wire

// File: hw/subtable_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "flow_table_macros.svh"

interface subtable_if;
    import flow_table_pkg::*;

    way_idx_t                idx;
    way_mask_t               rden;
    way_mask_t               wren;
    fce_t                    wdata;
    fce_t [`FT_WAYS-1:0]     q;

    modport client (output idx, output rden, output wren, output wdata, input q);

    modport memory (input idx, input rden, input wren, input wdata, output q);

endinterface

`default_nettype wire

// File: sim/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge, away from the DUT sampling edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: sim/tb_flow_table.sv
`timescale 1ns/1ps
`default_nettype none
`include "flow_table_macros.svh"

module tb_flow_table;
    import flow_table_pkg::*;

    localparam int WAYS         = `FT_WAYS;
    localparam int AW           = `FT_AWIDTH;
    localparam int TW           = `FT_TUPLE_W;
    localparam int DEPTH        = 1 << AW;
    localparam int BP_COUNT     = 4;
    localparam int BP_HOLD      = 6;
    localparam int RANDOM_PAIRS = 6;

    typedef struct packed {
        logic                 is_insert;
        tuple_t               tuple;
        haddr_t               haddr;
        logic [`FT_LEN_W-1:0] len;
        haddr_t               exp;
    } row_t;

    logic   clk;
    logic   rst;
    meta_t  in_meta_data;
    logic   in_meta_valid;
    logic   in_meta_ready;
    ctrl_t  in_ctrl_data;
    logic   in_ctrl_valid;
    logic   in_ctrl_ready;
    meta_t  out_meta_data;
    logic   out_meta_valid;
    logic   out_meta_ready;
    logic   out_ctrl_done;

    integer           seed;
    row_t             rows [$];
    tuple_t           used_tuples [$];
    logic [DEPTH-1:0] idx0_used;
    tuple_t           bp_tuples [BP_COUNT];
    fce_t             model_mem [WAYS][DEPTH];
    int               cycles = 0;
    int               cycle_limit = 0;
    int               meta_sent;

    clk_gen #(.PERIOD_NS(100), .RST_CYCLES(2)) u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    flow_table u_dut (
        .clk            (clk),
        .rst            (rst),
        .in_meta_data   (in_meta_data),
        .in_meta_valid  (in_meta_valid),
        .in_meta_ready  (in_meta_ready),
        .in_ctrl_data   (in_ctrl_data),
        .in_ctrl_valid  (in_ctrl_valid),
        .in_ctrl_ready  (in_ctrl_ready),
        .out_meta_data  (out_meta_data),
        .out_meta_valid (out_meta_valid),
        .out_meta_ready (out_meta_ready),
        .out_ctrl_done  (out_ctrl_done)
    );

    task abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED: %s expected %0h actual %0h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_lookup(input string name, input meta_t sent, input haddr_t exp,
                                input meta_t got);
        check_value({name, " tuple"}, sent.tuple, got.tuple);
        check_value({name, " host address"}, exp, got.haddr);
        check_value({name, " length"}, sent.len, got.len);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the DUT did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    // Bit b lands at (b + 7*way) mod TW and folds onto bit pos mod AW
    function automatic logic [AW-1:0] model_index(input tuple_t t, input int way);
        logic [AW-1:0] h;
        int            pos;
        h = '0;
        for (int b = 0; b < TW; b++) begin
            pos = (b + 7 * way) % TW;
            h[pos % AW] ^= t[b];
        end
        return h;
    endfunction

    function automatic haddr_t model_lookup(input tuple_t t);
        fce_t e;
        for (int w = 0; w < WAYS; w++) begin
            e = model_mem[w][model_index(t, w)];
            if (e.valid && e.tuple == t) begin
                return e.haddr;
            end
        end
        return '0;
    endfunction

    // Returns the stored address, zero when every way is taken
    function automatic haddr_t model_place(input tuple_t t, input haddr_t a);
        int   slot;
        fce_t e;
        slot = -1;
        for (int w = 0; w < WAYS; w++) begin
            e = model_mem[w][model_index(t, w)];
            if (slot < 0 && e.valid && e.tuple == t) begin
                slot = w;
            end
        end
        for (int w = 0; w < WAYS; w++) begin
            e = model_mem[w][model_index(t, w)];
            if (slot < 0 && !e.valid) begin
                slot = w;
            end
        end
        if (slot < 0) begin
            return '0;
        end
        model_mem[slot][model_index(t, slot)] = '{valid: 1'b1, tuple: t, haddr: a};
        return a;
    endfunction

    function automatic bit is_used(input tuple_t t);
        foreach (used_tuples[k]) begin
            if (used_tuples[k] == t) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic draw_fresh(output tuple_t t);
        do begin
            t = $random(seed);
        end while (is_used(t));
        used_tuples.push_back(t);
    endtask

    // Rotation only permutes the folded bits, so way 0 fixes every way's index
    task automatic draw_colliding(input logic [AW-1:0] idx0, output tuple_t t);
        do begin
            t = $random(seed);
        end while (is_used(t) || model_index(t, 0) != idx0);
        used_tuples.push_back(t);
    endtask

    // Keeps way 0 free at the new tuple's index, so its insert always lands
    task automatic draw_free_way0(output tuple_t t);
        do begin
            t = $random(seed);
        end while (is_used(t) || idx0_used[model_index(t, 0)]);
        idx0_used[model_index(t, 0)] = 1'b1;
        used_tuples.push_back(t);
    endtask

    task automatic add_row(input logic ins, input tuple_t t, input haddr_t a,
                           input logic [`FT_LEN_W-1:0] len, input haddr_t exp);
        row_t r;
        r.is_insert = ins;
        r.tuple     = t;
        r.haddr     = a;
        r.len       = len;
        r.exp       = exp;
        rows.push_back(r);
    endtask

    task automatic build_table();
        tuple_t        t0;
        tuple_t        t1;
        tuple_t        coll [WAYS];
        tuple_t        r;
        tuple_t        u;
        haddr_t        a;
        logic [AW-1:0] target;
        draw_fresh(t0);
        draw_fresh(t1);
        target            = model_index(t1, 0);
        idx0_used         = '0;
        idx0_used[target] = 1'b1;
        for (int k = 0; k < WAYS; k++) begin
            draw_colliding(target, coll[k]);
        end
        add_row(1'b0, t0, 32'hdead_beef, 16'd64, '0);
        add_row(1'b1, t1, 32'h1000_0001, '0, 32'h1000_0001);
        add_row(1'b0, t1, '0, 16'd128, 32'h1000_0001);
        add_row(1'b1, t1, 32'h1000_0002, '0, 32'h1000_0002);
        add_row(1'b0, t1, '0, 16'd256, 32'h1000_0002);
        // t1 and the first three fill the ways and the fourth is dropped
        for (int k = 0; k < WAYS; k++) begin
            add_row(1'b1, coll[k], 32'h2000_0000 + k, '0,
                    (k < WAYS - 1) ? 32'h2000_0000 + k : '0);
        end
        for (int k = 0; k < WAYS; k++) begin
            add_row(1'b0, coll[k], '0, 16'(60 + k),
                    (k < WAYS - 1) ? 32'h2000_0000 + k : '0);
        end
        add_row(1'b0, t1, '0, 16'd1500, 32'h1000_0002);
        for (int k = 0; k < RANDOM_PAIRS; k++) begin
            draw_free_way0(r);
            draw_fresh(u);
            a = $random(seed) | 32'h1;
            add_row(1'b1, r, a, '0, a);
            add_row(1'b0, u, $random(seed), 16'($random(seed)), '0);
            add_row(1'b0, r, '0, 16'($random(seed)), a);
            if (k == 0) begin
                bp_tuples[2] = r;
                bp_tuples[3] = u;
            end
        end
        bp_tuples[0] = t1;
        bp_tuples[1] = coll[1];
    endtask

    // Called on a falling edge; returns on the falling edge after the transfer
    task automatic send_meta(input meta_t m);
        in_meta_data  = m;
        in_meta_valid = 1'b1;
        while (!in_meta_ready) @(negedge clk);
        @(negedge clk);
        in_meta_valid = 1'b0;
        meta_sent     = meta_sent + 1;
    endtask

    task automatic send_ctrl(input tuple_t t, input haddr_t a);
        in_ctrl_data.tuple = t;
        in_ctrl_data.haddr = a;
        in_ctrl_valid      = 1'b1;
        while (!in_ctrl_ready) @(negedge clk);
        @(negedge clk);
        in_ctrl_valid = 1'b0;
    endtask

    task automatic get_result(output meta_t m);
        @(negedge clk);
        while (!out_meta_valid) @(negedge clk);
        m = out_meta_data;
    endtask

    task automatic wait_ctrl_done();
        @(negedge clk);
        while (!out_ctrl_done) @(negedge clk);
    endtask

    initial begin : main
        meta_t  m;
        meta_t  got;
        meta_t  first;
        meta_t  bp_sent [BP_COUNT];
        meta_t  bp_got [BP_COUNT];
        haddr_t exp;
        row_t   r;
        int     sent_before;

        in_meta_data   = '0;
        in_meta_valid  = 1'b0;
        in_ctrl_data   = '0;
        in_ctrl_valid  = 1'b0;
        out_meta_ready = 1'b1;
        meta_sent      = 0;
        seed           = 32'hf30a_f6af;
        for (int w = 0; w < WAYS; w++) begin
            for (int i = 0; i < DEPTH; i++) begin
                model_mem[w][i] = '0;
            end
        end
        build_table();
        cycle_limit = 40 * (rows.size() + BP_COUNT) + 50;

        wait (!rst);
        @(negedge clk);
        check_value("outputs idle after reset", '0, {out_meta_valid, out_ctrl_done});
        check_value("readies low during init sweep", '0, {in_meta_ready, in_ctrl_ready});
        while (!(in_meta_ready && in_ctrl_ready)) @(negedge clk);

        foreach (rows[i]) begin
            r = rows[i];
            if (r.is_insert) begin
                exp = model_place(r.tuple, r.haddr);
                check_value($sformatf("row %0d model cross-check", i), r.exp, exp);
                send_ctrl(r.tuple, r.haddr);
                wait_ctrl_done();
            end else begin
                exp = model_lookup(r.tuple);
                check_value($sformatf("row %0d model cross-check", i), r.exp, exp);
                m.tuple = r.tuple;
                m.haddr = r.haddr;
                m.len   = r.len;
                send_meta(m);
                get_result(got);
                check_lookup($sformatf("row %0d lookup", i), m, exp, got);
            end
        end

        // One lookup held in the FSM with the pipeline full behind it
        for (int j = 0; j < BP_COUNT; j++) begin
            bp_sent[j].tuple = bp_tuples[j];
            bp_sent[j].haddr = '0;
            bp_sent[j].len   = 16'(100 + j);
        end
        // Last row's result hands off before ready drops
        @(negedge clk);
        sent_before    = meta_sent;
        out_meta_ready = 1'b0;
        fork
            begin
                for (int j = 0; j < BP_COUNT; j++) begin
                    send_meta(bp_sent[j]);
                end
            end
            begin
                get_result(first);
                repeat (BP_HOLD) begin
                    @(negedge clk);
                    check_value("out_meta_valid held", 1, out_meta_valid);
                    check_value("out_meta_data stable", first, out_meta_data);
                end
                check_value("in_meta_ready under back-pressure", 0, in_meta_ready);
                check_value("lookups accepted while blocked", 1 + `FT_HASH_LAT,
                            meta_sent - sent_before);
                out_meta_ready = 1'b1;
                bp_got[0]      = first;
                for (int j = 1; j < BP_COUNT; j++) begin
                    get_result(bp_got[j]);
                end
            end
        join
        for (int j = 0; j < BP_COUNT; j++) begin
            check_lookup($sformatf("back-pressure lookup %0d", j), bp_sent[j],
                         model_lookup(bp_tuples[j]), bp_got[j]);
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
